// ==== hdl/z80_alu.sv ====
`timescale 1ns/100ps

module z80_alu #(
  parameter int width = z80_pkg::byte_w
) (
  input  z80_pkg::alu_op_e   op,
  input  logic [width-1:0]   lhs,
  input  logic [width-1:0]   rhs,
  output logic [width-1:0]   result
);

  // --------------------
  // operations
  // --------------------

  // no flags yet, results simply wrap at the width
  always_comb begin
    unique case (op)
      // lhs straight through
      z80_pkg::alu_pass: begin
        result = lhs;
      end
      z80_pkg::alu_inc: begin
        result = lhs + 1'b1;
      end
      z80_pkg::alu_dec: begin
        result = lhs - 1'b1;
      end
      // rhs only matters here
      z80_pkg::alu_add: begin
        result = lhs + rhs;
      end
    endcase
  end

endmodule

// ==== hdl/z80_bus_arbiter.sv ====
`timescale 1ns/100ps

module z80_bus_arbiter (
  input  z80_pkg::data_src_e  data_src,
  input  z80_pkg::addr_src_e  addr_src,
  input  z80_pkg::byte_t      data_in,
  input  z80_pkg::byte_t      a_q,
  input  z80_pkg::byte_t      rd_byte,
  input  z80_pkg::byte_t      temp_q,
  input  z80_pkg::byte_t      alu8_q,
  input  z80_pkg::word_t      mar_q,
  input  z80_pkg::word_t      rd_word,
  input  z80_pkg::word_t      alu16_q,
  output z80_pkg::byte_t      bus_data,
  output z80_pkg::word_t      bus_addr,
  output z80_pkg::byte_t      data_out,
  output logic                data_oe,
  output z80_pkg::word_t      addr_out,
  output logic                addr_oe
);

  // --------------------
  // data bus
  // --------------------

  // ext lets the pins feed the internal bus
  always_comb begin
    case (data_src)
      z80_pkg::dsrc_a:    bus_data = a_q;
      z80_pkg::dsrc_reg:  bus_data = rd_byte;
      z80_pkg::dsrc_temp: bus_data = temp_q;
      z80_pkg::dsrc_alu:  bus_data = alu8_q;
      default:            bus_data = data_in;
    endcase
  end

  assign data_oe  = (data_src != z80_pkg::dsrc_ext);
  // pins read zero when nothing inside drives
  assign data_out = data_oe ? bus_data : '0;

  // --------------------
  // address bus
  // --------------------

  always_comb begin
    case (addr_src)
      z80_pkg::asrc_mar:  bus_addr = mar_q;
      z80_pkg::asrc_pair: bus_addr = rd_word;
      z80_pkg::asrc_alu:  bus_addr = alu16_q;
      default:            bus_addr = '0;
    endcase
  end

  assign addr_oe  = (addr_src != z80_pkg::asrc_none);
  assign addr_out = addr_oe ? bus_addr : '0;

endmodule

// ==== hdl/z80_datapath.sv ====
`timescale 1ns/100ps

module z80_datapath (
  input  logic                clk,
  input  logic                rst,
  input  z80_pkg::byte_t      data_in,
  input  z80_pkg::data_src_e  data_src,
  input  z80_pkg::reg_sel_e   rd_reg,
  input  z80_pkg::addr_src_e  addr_src,
  input  z80_pkg::pair_sel_e  rd_pair,
  input  z80_pkg::alu_op_e    alu_op,
  input  z80_pkg::reg_sel_e   ld_reg,
  input  z80_pkg::pair_sel_e  ld_pair,
  input  logic                ld_a,
  input  logic                ld_temp,
  input  logic                ld_mar_hi,
  input  logic                ld_mar_lo,
  input  logic                ex_de_hl,
  input  logic                exx,
  input  logic                ex_af,
  output z80_pkg::byte_t      data_out,
  output logic                data_oe,
  output z80_pkg::word_t      addr_out,
  output logic                addr_oe
);

  // --------------------
  // internal buses
  // --------------------

  z80_pkg::byte_t internal_data;
  z80_pkg::word_t internal_addr;

  // register outputs
  z80_pkg::byte_t rd_byte;
  z80_pkg::word_t rd_word;
  z80_pkg::byte_t a_q;
  z80_pkg::byte_t temp_q;
  z80_pkg::word_t mar_q;

  // alu results
  z80_pkg::byte_t alu8_q;
  z80_pkg::word_t alu16_q;
  // temp widened for the 16 bit alu
  z80_pkg::word_t temp_ext;

  assign temp_ext = {{(z80_pkg::word_w - z80_pkg::byte_w){1'b0}}, temp_q};

  z80_regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .ld_reg   (ld_reg),
    .ld_pair  (ld_pair),
    .rd_reg   (rd_reg),
    .rd_pair  (rd_pair),
    .ex_de_hl (ex_de_hl),
    .exx      (exx),
    .bus_data (internal_data),
    .bus_addr (internal_addr),
    .rd_byte  (rd_byte),
    .rd_word  (rd_word)
  );

  z80_work_regs work_regs_inst (
    .clk       (clk),
    .rst       (rst),
    .ld_a      (ld_a),
    .ex_af     (ex_af),
    .ld_temp   (ld_temp),
    .ld_mar_hi (ld_mar_hi),
    .ld_mar_lo (ld_mar_lo),
    .bus_data  (internal_data),
    .bus_addr  (internal_addr),
    .a_q       (a_q),
    .temp_q    (temp_q),
    .mar_q     (mar_q)
  );

  // --------------------
  // alus
  // --------------------

  // accumulator against the data pins
  z80_alu #(.width(z80_pkg::byte_w)) alu8_inst (
    .op     (alu_op),
    .lhs    (a_q),
    .rhs    (data_in),
    .result (alu8_q)
  );

  // selected pair against temp, for address arithmetic
  z80_alu #(.width(z80_pkg::word_w)) alu16_inst (
    .op     (alu_op),
    .lhs    (rd_word),
    .rhs    (temp_ext),
    .result (alu16_q)
  );

  z80_bus_arbiter bus_arbiter_inst (
    .data_src (data_src),
    .addr_src (addr_src),
    .data_in  (data_in),
    .a_q      (a_q),
    .rd_byte  (rd_byte),
    .temp_q   (temp_q),
    .alu8_q   (alu8_q),
    .mar_q    (mar_q),
    .rd_word  (rd_word),
    .alu16_q  (alu16_q),
    .bus_data (internal_data),
    .bus_addr (internal_addr),
    .data_out (data_out),
    .data_oe  (data_oe),
    .addr_out (addr_out),
    .addr_oe  (addr_oe)
  );

endmodule

// ==== hdl/z80_pkg.sv ====
package z80_pkg;

  // --------------------
  // widths
  // --------------------

  // internal and external data bus
  localparam int byte_w = 8;
  // internal and external address bus
  localparam int word_w = 16;

  typedef logic [byte_w-1:0] byte_t;
  typedef logic [word_w-1:0] word_t;

  // --------------------
  // selects
  // --------------------

  // byte register select, pairs sit next to each other with the high byte first
  // so a pair select times two gives the high byte slot
  typedef enum logic [3:0] {
    reg_b,
    reg_c,
    reg_d,
    reg_e,
    reg_h,
    reg_l,
    reg_ixh,
    reg_ixl,
    reg_iyh,
    reg_iyl,
    reg_sph,
    reg_spl,
    reg_none
  } reg_sel_e;

  // register pair select, same order as the byte registers
  typedef enum logic [2:0] {
    pair_bc,
    pair_de,
    pair_hl,
    pair_ix,
    pair_iy,
    pair_sp,
    pair_none
  } pair_sel_e;

  // data bus driver, ext means nothing internal drives it
  typedef enum logic [2:0] {
    dsrc_ext,
    dsrc_a,
    dsrc_reg,
    dsrc_temp,
    dsrc_alu
  } data_src_e;

  // address bus driver
  typedef enum logic [1:0] {
    asrc_none,
    asrc_mar,
    asrc_pair,
    asrc_alu
  } addr_src_e;

  // alu opcodes, shared by both alus
  typedef enum logic [1:0] {
    alu_pass,
    alu_inc,
    alu_dec,
    alu_add
  } alu_op_e;

endpackage

// ==== hdl/z80_regfile.sv ====
`timescale 1ns/100ps

module z80_regfile (
  input  logic                clk,
  input  logic                rst,
  input  z80_pkg::reg_sel_e   ld_reg,
  input  z80_pkg::pair_sel_e  ld_pair,
  input  z80_pkg::reg_sel_e   rd_reg,
  input  z80_pkg::pair_sel_e  rd_pair,
  input  logic                ex_de_hl,
  input  logic                exx,
  input  z80_pkg::byte_t      bus_data,
  input  z80_pkg::word_t      bus_addr,
  output z80_pkg::byte_t      rd_byte,
  output z80_pkg::word_t      rd_word
);

  // --------------------
  // storage
  // --------------------

  // main set, indexed by reg_sel_e
  z80_pkg::byte_t regs [z80_pkg::reg_b:z80_pkg::reg_spl];
  // shadow set, only b through l have one
  z80_pkg::byte_t shadow [z80_pkg::reg_b:z80_pkg::reg_l];

  // slot numbers of the pair halves
  logic [3:0] ld_hi_idx;
  logic [3:0] ld_lo_idx;
  logic [3:0] rd_hi_idx;
  logic [3:0] rd_lo_idx;

  logic ld_pair_en;
  logic ld_reg_en;

  // pair n lives in slots 2n and 2n+1
  assign ld_hi_idx = {ld_pair, 1'b0};
  assign ld_lo_idx = {ld_pair, 1'b1};
  assign rd_hi_idx = {rd_pair, 1'b0};
  assign rd_lo_idx = {rd_pair, 1'b1};

  assign ld_pair_en = (ld_pair < z80_pkg::pair_none);

  // a byte load into a half of the pair being loaded loses to the pair load
  assign ld_reg_en = (ld_reg < z80_pkg::reg_none) &&
                     !(ld_pair_en && (ld_reg[3:1] == ld_pair));

  // --------------------
  // load and exchange
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = z80_pkg::reg_b; i <= z80_pkg::reg_spl; i++) begin
        regs[i] <= '0;
      end
      for (int i = z80_pkg::reg_b; i <= z80_pkg::reg_l; i++) begin
        shadow[i] <= '0;
      end
    end else if (exx) begin
      // bc, de and hl trade places with the shadow set in one cycle
      for (int i = z80_pkg::reg_b; i <= z80_pkg::reg_l; i++) begin
        regs[i]   <= shadow[i];
        shadow[i] <= regs[i];
      end
    end else if (ex_de_hl) begin
      // point to point swap, no trip over the data bus
      regs[z80_pkg::reg_d] <= regs[z80_pkg::reg_h];
      regs[z80_pkg::reg_e] <= regs[z80_pkg::reg_l];
      regs[z80_pkg::reg_h] <= regs[z80_pkg::reg_d];
      regs[z80_pkg::reg_l] <= regs[z80_pkg::reg_e];
    end else begin
      // 16 bit load from the address bus, high byte into the first register
      if (ld_pair_en) begin
        regs[ld_hi_idx] <= bus_addr[z80_pkg::word_w-1:z80_pkg::byte_w];
        regs[ld_lo_idx] <= bus_addr[z80_pkg::byte_w-1:0];
      end
      // 8 bit load from the data bus
      if (ld_reg_en) begin
        regs[ld_reg] <= bus_data;
      end
    end
  end

  // --------------------
  // read ports
  // --------------------

  // single byte toward the data bus
  always_comb begin
    rd_byte = '0;
    if (rd_reg < z80_pkg::reg_none) begin
      rd_byte = regs[rd_reg];
    end
  end

  // register pair toward the address bus
  always_comb begin
    rd_word = '0;
    if (rd_pair < z80_pkg::pair_none) begin
      rd_word = {regs[rd_hi_idx], regs[rd_lo_idx]};
    end
  end

endmodule

// ==== hdl/z80_work_regs.sv ====
`timescale 1ns/100ps

module z80_work_regs (
  input  logic            clk,
  input  logic            rst,
  input  logic            ld_a,
  input  logic            ex_af,
  input  logic            ld_temp,
  input  logic            ld_mar_hi,
  input  logic            ld_mar_lo,
  input  z80_pkg::byte_t  bus_data,
  input  z80_pkg::word_t  bus_addr,
  output z80_pkg::byte_t  a_q,
  output z80_pkg::byte_t  temp_q,
  output z80_pkg::word_t  mar_q
);

  // second accumulator for ex af
  z80_pkg::byte_t a_shadow;

  // --------------------
  // accumulator
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      a_q      <= '0;
      a_shadow <= '0;
    end else if (ex_af) begin
      // exchange wins, ld_a is dropped this cycle
      a_q      <= a_shadow;
      a_shadow <= a_q;
    end else if (ld_a) begin
      a_q <= bus_data;
    end
  end

  // --------------------
  // temp and mar
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      temp_q <= '0;
      mar_q  <= '0;
    end else begin
      if (ld_temp) begin
        temp_q <= bus_data;
      end
      // each half has its own enable, both together load the whole word
      if (ld_mar_hi) begin
        mar_q[z80_pkg::word_w-1:z80_pkg::byte_w] <=
          bus_addr[z80_pkg::word_w-1:z80_pkg::byte_w];
      end
      if (ld_mar_lo) begin
        mar_q[z80_pkg::byte_w-1:0] <= bus_addr[z80_pkg::byte_w-1:0];
      end
    end
  end

endmodule

// ==== list.f ====
hdl/z80_pkg.sv
hdl/z80_alu.sv
hdl/z80_regfile.sv
hdl/z80_work_regs.sv
hdl/z80_bus_arbiter.sv
hdl/z80_datapath.sv
tb/z80_datapath_assert.sv
tb/tb_z80_datapath.sv

// ==== tb/tb_z80_datapath.sv ====
`timescale 1ns/100ps

module tb_z80_datapath;

  localparam int period = 100;

  logic clk;
  logic rst;
  z80_pkg::byte_t data_in;
  z80_pkg::data_src_e data_src;
  z80_pkg::reg_sel_e rd_reg;
  z80_pkg::addr_src_e addr_src;
  z80_pkg::pair_sel_e rd_pair;
  z80_pkg::alu_op_e alu_op;
  z80_pkg::reg_sel_e ld_reg;
  z80_pkg::pair_sel_e ld_pair;
  logic ld_a;
  logic ld_temp;
  logic ld_mar_hi;
  logic ld_mar_lo;
  logic ex_de_hl;
  logic exx;
  logic ex_af;
  z80_pkg::byte_t data_out;
  logic data_oe;
  z80_pkg::word_t addr_out;
  logic addr_oe;

  // --------------------
  // expected state
  // --------------------

  // b c d e h l ixh ixl iyh iyl sph spl, pair p in slots 2p and 2p+1
  z80_pkg::byte_t m_reg [12];
  z80_pkg::byte_t m_sh [6];
  z80_pkg::byte_t m_a;
  z80_pkg::byte_t m_a_sh;
  z80_pkg::byte_t m_temp;
  z80_pkg::word_t m_mar;

  int n_pass;
  int n_fail;
  int test_fail;

  z80_datapath z80_datapath_inst (
    .clk(clk), .rst(rst), .data_in(data_in), .data_src(data_src), .rd_reg(rd_reg),
    .addr_src(addr_src), .rd_pair(rd_pair), .alu_op(alu_op), .ld_reg(ld_reg),
    .ld_pair(ld_pair), .ld_a(ld_a), .ld_temp(ld_temp), .ld_mar_hi(ld_mar_hi),
    .ld_mar_lo(ld_mar_lo), .ex_de_hl(ex_de_hl), .exx(exx), .ex_af(ex_af),
    .data_out(data_out), .data_oe(data_oe), .addr_out(addr_out), .addr_oe(addr_oe)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  function automatic z80_pkg::word_t pair_val(input int p);
    return {m_reg[2 * p], m_reg[2 * p + 1]};
  endfunction

  // pass, inc, dec, add wrapping at w bits
  function automatic logic [15:0] alu_ref(input int op, input logic [15:0] lhs,
                                          input logic [15:0] rhs, input int w);
    logic [15:0] r;
    case (op)
      0: r = lhs;
      1: r = lhs + 16'd1;
      2: r = lhs - 16'd1;
      default: r = lhs + rhs;
    endcase
    return (w == 8) ? (r & 16'h00ff) : r;
  endfunction

  // n clock edges, each one guarded
  task automatic wait_edges(input int n, input logic rising);
    bit seen;
    for (int i = 0; i < n; i++) begin
      seen = 1'b0;
      fork
        begin
          if (rising) @(posedge clk);
          else @(negedge clk);
          seen = 1'b1;
        end
        #(2 * period);
      join_any
      disable fork;
      if (!seen) begin
        $display("timeout: clock edge did not arrive within two periods");
        $display("Test failed");
        $finish;
      end
    end
  endtask

  task automatic set_idle();
    data_in   = '0;
    data_src  = z80_pkg::dsrc_ext;
    rd_reg    = z80_pkg::reg_none;
    addr_src  = z80_pkg::asrc_none;
    rd_pair   = z80_pkg::pair_none;
    alu_op    = z80_pkg::alu_pass;
    ld_reg    = z80_pkg::reg_none;
    ld_pair   = z80_pkg::pair_none;
    ld_a      = 1'b0;
    ld_temp   = 1'b0;
    ld_mar_hi = 1'b0;
    ld_mar_lo = 1'b0;
    ex_de_hl  = 1'b0;
    exx       = 1'b0;
    ex_af     = 1'b0;
  endtask

  task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) n_pass++;
    else begin
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, act);
      n_fail++;
      test_fail++;
    end
  endtask

  // outputs are sampled at the rising edge, before the loads land
  task automatic finish_cycle(input string dname, input logic [15:0] d_exp,
                              input string aname, input logic [15:0] a_exp);
    wait_edges(1, 1'b1);
    if (dname != "") compare(dname, d_exp, data_out);
    if (aname != "") compare(aname, a_exp, addr_out);
    wait_edges(1, 1'b0);
    set_idle();
  endtask

  task automatic load_reg(input int r, input z80_pkg::byte_t v);
    data_in = v;
    ld_reg  = z80_pkg::reg_sel_e'(r);
    finish_cycle("", 0, "", 0);
    m_reg[r] = v;
  endtask

  task automatic read_regs(input int first, input int last);
    for (int r = first; r <= last; r++) begin
      data_src = z80_pkg::dsrc_reg;
      rd_reg   = z80_pkg::reg_sel_e'(r);
      finish_cycle($sformatf("data_out (reg %0d)", r), m_reg[r], "", 0);
    end
  endtask

  task automatic read_work();
    data_src = z80_pkg::dsrc_a;
    finish_cycle("data_out (a)", m_a, "", 0);
    data_src = z80_pkg::dsrc_temp;
    finish_cycle("data_out (temp)", m_temp, "", 0);
    addr_src = z80_pkg::asrc_mar;
    finish_cycle("", 0, "addr_out (mar)", m_mar);
  endtask

  // a byte load rides along and must be dropped
  task automatic exx_cycle();
    z80_pkg::byte_t t;
    exx     = 1'b1;
    ld_reg  = z80_pkg::reg_c;
    data_in = ~m_reg[1];
    finish_cycle("", 0, "", 0);
    for (int i = 0; i < 6; i++) begin
      t        = m_reg[i];
      m_reg[i] = m_sh[i];
      m_sh[i]  = t;
    end
  endtask

  // accumulator trades places with its shadow
  task automatic ex_af_cycle();
    z80_pkg::byte_t t;
    ex_af = 1'b1;
    finish_cycle("", 0, "", 0);
    t      = m_a;
    m_a    = m_a_sh;
    m_a_sh = t;
  endtask

  task automatic end_test(input string name);
    $display("%s done, %0d errors", name, test_fail);
    test_fail = 0;
  endtask

  initial begin
    z80_pkg::byte_t d;
    z80_pkg::word_t w;
    void'($urandom(32'h3f47b37e));
    set_idle();
    rst = 1'b1;
    n_pass = 0;
    n_fail = 0;
    test_fail = 0;
    foreach (m_reg[i]) m_reg[i] = '0;
    foreach (m_sh[i]) m_sh[i] = '0;
    m_a = '0;
    m_a_sh = '0;
    m_temp = '0;
    m_mar = '0;
    wait_edges(5, 1'b1);
    wait_edges(1, 1'b0);
    rst = 1'b0;

    // ---- reset ----
    wait_edges(1, 1'b1);
    compare("data_oe", 0, data_oe);
    compare("addr_oe", 0, addr_oe);
    wait_edges(1, 1'b0);
    read_regs(0, 11);
    read_work();
    end_test("reset");

    // ---- byte path ----
    for (int r = 0; r < 12; r++) load_reg(r, $urandom);
    d = $urandom;
    data_in = d;
    ld_a = 1'b1;
    finish_cycle("", 0, "", 0);
    m_a = d;
    d = $urandom;
    data_in = d;
    ld_temp = 1'b1;
    finish_cycle("", 0, "", 0);
    m_temp = d;
    read_regs(0, 11);
    read_work();
    end_test("byte path");

    // ---- address path ----
    addr_src = z80_pkg::asrc_pair;
    rd_pair = z80_pkg::pair_bc;
    ld_mar_hi = 1'b1;
    finish_cycle("", 0, "", 0);
    m_mar[15:8] = m_reg[0];
    addr_src = z80_pkg::asrc_pair;
    rd_pair = z80_pkg::pair_de;
    ld_mar_lo = 1'b1;
    finish_cycle("", 0, "", 0);
    m_mar[7:0] = m_reg[3];
    read_work();
    // mar low byte changes per pair so each pair gets its own value
    for (int p = 0; p < 6; p++) begin
      addr_src = z80_pkg::asrc_alu;
      rd_pair = z80_pkg::pair_sel_e'(p);
      alu_op = z80_pkg::alu_inc;
      ld_mar_lo = 1'b1;
      finish_cycle("", 0, "", 0);
      w = alu_ref(1, pair_val(p), 0, 16);
      m_mar[7:0] = w[7:0];
      addr_src = z80_pkg::asrc_mar;
      ld_pair = z80_pkg::pair_sel_e'(p);
      finish_cycle("", 0, "", 0);
      m_reg[2 * p] = m_mar[15:8];
      m_reg[2 * p + 1] = m_mar[7:0];
    end
    for (int p = 0; p < 6; p++) begin
      addr_src = z80_pkg::asrc_pair;
      rd_pair = z80_pkg::pair_sel_e'(p);
      finish_cycle("", 0, $sformatf("addr_out (pair %0d)", p), pair_val(p));
    end
    end_test("address path");

    // ---- alus ----
    for (int op = 0; op < 4; op++) begin
      d = $urandom;
      data_in = d;
      data_src = z80_pkg::dsrc_alu;
      addr_src = z80_pkg::asrc_alu;
      rd_pair = z80_pkg::pair_sel_e'(op + 1);
      alu_op = z80_pkg::alu_op_e'(op);
      finish_cycle("data_out (alu8)", alu_ref(op, m_a, d, 8),
                   "addr_out (alu16)", alu_ref(op, pair_val(op + 1), {8'h00, m_temp}, 16));
    end
    end_test("alus");

    // ---- exchanges ----
    ex_de_hl = 1'b1;
    ld_reg = z80_pkg::reg_d;
    data_in = ~m_reg[2];
    finish_cycle("", 0, "", 0);
    d = m_reg[2];
    m_reg[2] = m_reg[4];
    m_reg[4] = d;
    d = m_reg[3];
    m_reg[3] = m_reg[5];
    m_reg[5] = d;
    read_regs(0, 5);
    exx_cycle();
    for (int r = 0; r < 6; r++) load_reg(r, $urandom);
    exx_cycle();
    read_regs(0, 5);
    exx_cycle();
    read_regs(0, 5);
    d = $urandom;
    data_in = d;
    ld_a = 1'b1;
    finish_cycle("", 0, "", 0);
    m_a = d;
    // load in the ex_af cycle is dropped
    ld_a = 1'b1;
    data_in = ~m_a;
    ex_af_cycle();
    read_work();
    // new value into the swapped-in accumulator
    d = $urandom;
    data_in = d;
    ld_a = 1'b1;
    finish_cycle("", 0, "", 0);
    m_a = d;
    ex_af_cycle();
    read_work();
    ex_af_cycle();
    read_work();
    end_test("exchanges");

    n_fail += z80_datapath_inst.z80_datapath_assert_inst.n_err;
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb/z80_datapath_assert.sv ====
`timescale 1ns/100ps

module z80_datapath_assert (
  input logic                clk,
  input logic                rst,
  input z80_pkg::data_src_e  data_src,
  input z80_pkg::addr_src_e  addr_src,
  input logic                data_oe,
  input logic                addr_oe,
  input z80_pkg::byte_t      data_out,
  input z80_pkg::word_t      addr_out,
  input z80_pkg::byte_t      data_in,
  input z80_pkg::byte_t      a_q,
  input logic                ld_a,
  input logic                ex_af
);

  // number of failed assertions
  int n_err = 0;

  // --------------------
  // bus enables
  // --------------------

  // enables depend on the selects only
  data_oe_follows_src: assert property (@(posedge clk)
    data_oe == (data_src != z80_pkg::dsrc_ext))
    else begin
      $error("data_oe does not match data_src");
      n_err++;
    end

  addr_oe_follows_src: assert property (@(posedge clk)
    addr_oe == (addr_src != z80_pkg::asrc_none))
    else begin
      $error("addr_oe does not match addr_src");
      n_err++;
    end

  // undriven pins read zero
  data_out_quiet: assert property (@(posedge clk) !data_oe |-> data_out == '0)
    else begin
      $error("data_out not zero while data_oe is low");
      n_err++;
    end

  addr_out_quiet: assert property (@(posedge clk) !addr_oe |-> addr_out == '0)
    else begin
      $error("addr_out not zero while addr_oe is low");
      n_err++;
    end

  // --------------------
  // accumulator load
  // --------------------

  // pins feed the bus, so A takes the previous data_in
  a_load_from_pins: assert property (@(posedge clk) disable iff (rst)
    (ld_a && !ex_af && data_src == z80_pkg::dsrc_ext) |=> (a_q == $past(data_in)))
    else begin
      $error("accumulator missed a load from data_in");
      n_err++;
    end

endmodule

bind z80_datapath z80_datapath_assert z80_datapath_assert_inst (
  .clk      (clk),
  .rst      (rst),
  .data_src (data_src),
  .addr_src (addr_src),
  .data_oe  (data_oe),
  .addr_oe  (addr_oe),
  .data_out (data_out),
  .addr_out (addr_out),
  .data_in  (data_in),
  .a_q      (a_q),
  .ld_a     (ld_a),
  .ex_af    (ex_af)
);
